// File: rtl/alu_decode.sv
// ALU control decode for the execute stage
// Maps opcode class and funct to an ALU operation, picks the destination
// register and flags fixed-amount shifts

`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module alu_decode
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  id_ex_t             id_ex,
	output alu_ctrl_e          alu_ctrl,
	output logic [`REG_AW-1:0] write_reg,
	output logic               shift_by_shamt
);

	funct_e    funct;     // R-type function field
	alu_ctrl_e funct_ctrl; // Operation when class is FUNCT_OP

	assign funct = funct_e'(id_ex.imm[5:0]); // funct rides in low imm bits

	// --------------------
	// R-type function decode
	// --------------------
	always_comb
	begin
		case (funct)
			SLL, SLLV: funct_ctrl = A_SLL; // Fixed and variable share the op
			SRL, SRLV: funct_ctrl = A_SRL;
			SRA, SRAV: funct_ctrl = A_SRA;
			MULT:      funct_ctrl = A_MUL;
			DIV:       funct_ctrl = A_DIV;
			ADD, ADDU: funct_ctrl = A_ADD; // No trap, so addu is just add
			SUB:       funct_ctrl = A_SUB;
			AND:       funct_ctrl = A_AND;
			OR:        funct_ctrl = A_OR;
			XOR:       funct_ctrl = A_XOR;
			NOR:       funct_ctrl = A_NOR;
			SLT:       funct_ctrl = A_SLT;
			default:   funct_ctrl = A_MUL; // Unknown codes land on mul
		endcase
	end

	// --------------------
	// Opcode class decode
	// --------------------
	always_comb
	begin
		case (id_ex.alu_op)
			ADD_OP:   alu_ctrl = A_ADD;
			SUB_OP:   alu_ctrl = A_SUB;
			FUNCT_OP: alu_ctrl = funct_ctrl;
			AND_OP:   alu_ctrl = A_AND;
			OR_OP:    alu_ctrl = A_OR;
			SLT_OP:   alu_ctrl = A_SLT;
			LUI_OP:   alu_ctrl = A_LUI;
			default:  alu_ctrl = A_LUI; // Spare class codes
		endcase
	end

	// Only sll, srl, sra take the amount from the instruction
	always_comb
	begin
		shift_by_shamt = 1'b0;
		if (id_ex.alu_op == FUNCT_OP)
		begin
			case (funct)
				SLL, SRL, SRA: shift_by_shamt = 1'b1;
				default:       shift_by_shamt = 1'b0;
			endcase
		end
	end

	// R-type writes rd, I-type writes rt
	assign write_reg = id_ex.reg_dst_rd ? id_ex.rd : id_ex.rt;

endmodule

`default_nettype wire

// File: rtl/ex_macros.svh
// Execute stage sizing macros
// Word width and register file geometry shared by packages and RTL

`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// --------------------
// Datapath
// --------------------
`define XLEN 32 // Integer word width

// --------------------
// Register file geometry
// --------------------
`define REG_AW 5                     // Register address bits
`define REG_COUNT (1 << `REG_AW)     // Architectural registers, r0 hardwired

`endif

// File: rtl/execute_core.sv
// Execute stage ALU and EX/MEM pipeline register
// Integer ops with zero and signed overflow flags, registered with
// stall hold and flush of the control groups

`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module execute_core
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic               clk,
	input  logic               reset,
	input  logic               stall,      // Hold EX/MEM, MEM not ready
	input  logic               flush,      // Kill the instruction in EX
	input  id_ex_t             id_ex,      // For the control groups
	input  alu_ctrl_e          alu_ctrl,
	input  logic [`XLEN-1:0]   op_a,
	input  logic [`XLEN-1:0]   op_b,
	input  logic [`XLEN-1:0]   store_data,
	input  logic [`REG_AW-1:0] write_reg,
	output ex_mem_t            ex_mem
);

	localparam int MSB     = `XLEN - 1;
	localparam int SHW     = $clog2(`XLEN); // Shift amount bits
	localparam int LUI_SH  = 16;            // Upper half

	logic [`XLEN-1:0] result;
	logic             over;
	logic             zero;
	ex_mem_t          ex_next; // Value loaded on the next edge

	// --------------------
	// ALU
	// --------------------
	always_comb
	begin
		result = '0;
		over   = 1'b0; // Only add and sub can overflow
		case (alu_ctrl)
			A_ADD:
			begin
				result = op_a + op_b;
				// Like signs in, other sign out
				over = (op_a[MSB] == op_b[MSB]) && (result[MSB] != op_a[MSB]);
			end
			A_SUB:
			begin
				result = op_a - op_b;
				// Unlike signs in, result sign differs from A
				over = (op_a[MSB] != op_b[MSB]) && (result[MSB] != op_a[MSB]);
			end
			A_AND: result = op_a & op_b;
			A_OR:  result = op_a | op_b;
			A_XOR: result = op_a ^ op_b;
			A_NOR: result = ~(op_a | op_b);
			A_SLT: result = {{(`XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			A_MUL: result = op_a * op_b; // Low word kept
			A_DIV:
			begin
				if (op_b == '0)
					result = '1; // Divide by zero gives all ones
				else
					result = op_a / op_b; // Unsigned quotient
			end
			A_SLL: result = op_b << op_a[SHW-1:0];
			A_SRL: result = op_b >> op_a[SHW-1:0];
			A_SRA: result = $unsigned($signed(op_b) >>> op_a[SHW-1:0]); // Sign fill
			A_LUI: result = op_b << LUI_SH;
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

	// --------------------
	// Next EX/MEM contents
	// --------------------
	always_comb
	begin
		ex_next.result     = result;
		ex_next.store_data = store_data;
		ex_next.write_reg  = write_reg;
		ex_next.zero       = zero;
		ex_next.over       = over;
		// Flush turns the instruction into a bubble, data still loads
		ex_next.mem_ctrl   = flush ? '0 : id_ex.mem_ctrl;
		ex_next.wb_ctrl    = flush ? '0 : id_ex.wb_ctrl;
	end

	// --------------------
	// EX/MEM register
	// --------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			ex_mem <= '0; // No stray writes after reset
		else if (!stall)
			ex_mem <= ex_next; // Stall wins over flush
	end

endmodule

`default_nettype wire

// File: rtl/execute_stage.sv
// Execute stage of the five-stage integer pipeline
// Operand forwarding and ALU decode in parallel, feeding the ALU and
// the EX/MEM register

`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module execute_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  logic    stall,
	input  logic    flush,
	input  id_ex_t  id_ex,  // From ID/EX
	input  wb_fwd_t wb,     // WB bypass
	output ex_mem_t ex_mem  // To MEM
);

	// Decode to operand select and core
	alu_ctrl_e          alu_ctrl;
	logic [`REG_AW-1:0] write_reg;
	logic               shift_by_shamt;

	// Operands into the core
	logic [`XLEN-1:0]   op_a;
	logic [`XLEN-1:0]   op_b;
	logic [`XLEN-1:0]   store_data;

	operand_select u_operand_select (
		.id_ex          (id_ex),
		.ex_mem         (ex_mem),         // Held value while stalled
		.wb             (wb),
		.shift_by_shamt (shift_by_shamt),
		.op_a           (op_a),
		.op_b           (op_b),
		.store_data     (store_data),
		.fwd_a          (),
		.fwd_b          ()
	);

	alu_decode u_alu_decode (
		.id_ex          (id_ex),
		.alu_ctrl       (alu_ctrl),
		.write_reg      (write_reg),
		.shift_by_shamt (shift_by_shamt)
	);

	execute_core u_execute_core (
		.clk        (clk),
		.reset      (reset),
		.stall      (stall),
		.flush      (flush),
		.id_ex      (id_ex),
		.alu_ctrl   (alu_ctrl),
		.op_a       (op_a),
		.op_b       (op_b),
		.store_data (store_data),
		.write_reg  (write_reg),
		.ex_mem     (ex_mem)
	);

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
// Instruction set encodings seen by the execute stage
// ALU opcode classes from decode, R-type function codes, ALU operations

`default_nettype none

package isa_pkg;

	// --------------------
	// Opcode class from ID
	// --------------------
	typedef enum logic [3:0] {
		ADD_OP   = 4'd0, // Loads, stores, addi
		SUB_OP   = 4'd1, // Branch compare
		FUNCT_OP = 4'd2, // R-type, look at funct
		AND_OP   = 4'd3, // andi
		OR_OP    = 4'd4, // ori
		SLT_OP   = 4'd5, // slti
		LUI_OP   = 4'd6  // lui, also the fallback class
	} alu_op_e;

	// R-type function field
	typedef enum logic [5:0] {
		SLL  = 6'd0,
		SRL  = 6'd2,
		SRA  = 6'd3,
		SLLV = 6'd4,  // Variable shifts take amount from rs
		SRLV = 6'd6,
		SRAV = 6'd7,
		MULT = 6'd24, // Low word only
		DIV  = 6'd26, // Unsigned
		ADD  = 6'd32,
		ADDU = 6'd33,
		SUB  = 6'd34,
		AND  = 6'd36,
		OR   = 6'd37,
		XOR  = 6'd38,
		NOR  = 6'd39,
		SLT  = 6'd42
	} funct_e;

	// --------------------
	// ALU operation select
	// --------------------
	typedef enum logic [3:0] {
		A_ADD = 4'd0,
		A_SUB = 4'd1,
		A_AND = 4'd2,
		A_OR  = 4'd3,
		A_XOR = 4'd4,
		A_NOR = 4'd5,
		A_SLT = 4'd6,  // Signed compare
		A_MUL = 4'd7,  // Also what unknown funct codes become
		A_DIV = 4'd8,
		A_SLL = 4'd10, // Code 9 unused
		A_SRL = 4'd11,
		A_SRA = 4'd12,
		A_LUI = 4'd13
	} alu_ctrl_e;

endpackage

`default_nettype wire

// File: rtl/operand_select.sv
// Forwarding unit and ALU operand multiplexers
// Resolves rs/rt against EX/MEM and WB, then picks shamt or imm where needed

`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module operand_select
	import pipe_pkg::*;
(
	input  id_ex_t           id_ex,          // Bundle from ID/EX
	input  ex_mem_t          ex_mem,         // Current EX/MEM register
	input  wb_fwd_t          wb,             // Bypass from WB
	input  logic             shift_by_shamt, // Fixed shift, A from shamt field
	output logic [`XLEN-1:0] op_a,
	output logic [`XLEN-1:0] op_b,
	output logic [`XLEN-1:0] store_data,
	output fwd_sel_e         fwd_a,
	output fwd_sel_e         fwd_b
);

	localparam int SHAMT_LO = 6;  // shamt sits in imm[10:6]
	localparam int SHAMT_HI = 10;

	logic [`XLEN-1:0] reg_a; // rs after forwarding
	logic [`XLEN-1:0] reg_b; // rt after forwarding

	// --------------------
	// Forwarding decision
	// --------------------

	// EX/MEM checked first so the younger producer wins
	function automatic fwd_sel_e fwd_pick(
		input logic [`REG_AW-1:0] src,
		input ex_mem_t            mem_q,
		input wb_fwd_t            wb_in
	);
		fwd_sel_e sel;
		sel = FWD_NONE;
		if (mem_q.wb_ctrl.reg_write && (mem_q.write_reg != '0) && (mem_q.write_reg == src))
			sel = FWD_MEM;
		else if (wb_in.reg_write && (wb_in.rd != '0) && (wb_in.rd == src))
			sel = FWD_WB;
		return sel;
	endfunction

	assign fwd_a = fwd_pick(id_ex.rs, ex_mem, wb);
	assign fwd_b = fwd_pick(id_ex.rt, ex_mem, wb);

	// --------------------
	// Register operands
	// --------------------
	always_comb
	begin
		case (fwd_a)
			FWD_MEM: reg_a = ex_mem.result; // Previous instruction
			FWD_WB:  reg_a = wb.data;       // Two back
			default: reg_a = id_ex.rs_data;
		endcase
	end

	always_comb
	begin
		case (fwd_b)
			FWD_MEM: reg_b = ex_mem.result;
			FWD_WB:  reg_b = wb.data;
			default: reg_b = id_ex.rt_data;
		endcase
	end

	// --------------------
	// ALU inputs
	// --------------------

	// Zero-extended shamt for sll/srl/sra
	assign op_a = shift_by_shamt
		? {{(`XLEN-(SHAMT_HI-SHAMT_LO+1)){1'b0}}, id_ex.imm[SHAMT_HI:SHAMT_LO]}
		: reg_a;

	assign op_b = id_ex.alu_src_imm ? id_ex.imm : reg_b; // I-type takes imm

	// Stores need rt itself, not the immediate
	assign store_data = reg_b;

endmodule

`default_nettype wire

// File: rtl/pipe_pkg.sv
// Pipeline register types around the execute stage
// ID/EX bundle, WB bypass, EX/MEM register and forwarding select

`default_nettype none

`include "ex_macros.svh"

package pipe_pkg;

	import isa_pkg::*;

	// Operand source picked by forwarding
	typedef enum logic [1:0] {
		FWD_NONE = 2'd0, // Register file value from ID
		FWD_WB   = 2'd1, // Write-back bypass
		FWD_MEM  = 2'd2  // EX/MEM result, youngest
	} fwd_sel_e;

	// --------------------
	// Control groups
	// --------------------
	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic mem_byte; // Byte access instead of word
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg; // Load data rather than ALU result
	} wb_ctrl_t;

	// --------------------
	// Stage bundles
	// --------------------
	typedef struct packed {
		logic [`XLEN-1:0]   rs_data;
		logic [`XLEN-1:0]   rt_data;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   imm;         // Already sign-extended, funct in [5:0]
		alu_op_e            alu_op;
		logic               alu_src_imm; // Operand B from imm
		logic               reg_dst_rd;  // Write rd, else rt
		mem_ctrl_t          mem_ctrl;
		wb_ctrl_t           wb_ctrl;
	} id_ex_t; // 122 bits

	typedef struct packed {
		logic               reg_write;
		logic [`REG_AW-1:0] rd;
		logic [`XLEN-1:0]   data;
	} wb_fwd_t; // 38 bits

	typedef struct packed {
		logic [`XLEN-1:0]   result;
		logic [`XLEN-1:0]   store_data;
		logic [`REG_AW-1:0] write_reg;
		logic               zero;
		logic               over;
		mem_ctrl_t          mem_ctrl;
		wb_ctrl_t           wb_ctrl;
	} ex_mem_t; // 76 bits

endpackage

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/operand_select.sv
rtl/alu_decode.sv
rtl/execute_core.sv
rtl/execute_stage.sv
verification/execute_stage_sva.sv
verification/execute_stage_tb.sv

// File: verification/execute_stage_sva.sv
// Bound checker for the execute stage
// Forwarding never targets r0, stall holds EX/MEM, flush kills control

`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module execute_stage_sva
	import pipe_pkg::*;
(
	input logic             clk,
	input logic             reset,
	input logic             stall,
	input logic             flush,
	input id_ex_t           id_ex,
	input ex_mem_t          ex_mem,
	input logic             shift_by_shamt,
	input logic [`XLEN-1:0] op_a,
	input logic [`XLEN-1:0] store_data
);

	int fail_count = 0; // Assertion failures so far

	// --------------------
	// Forwarding
	// --------------------

	// r0 reads must see the register file value whatever EX/MEM or WB hold
	rs_r0_not_forwarded: assert property (@(posedge clk) disable iff (reset)
		((id_ex.rs == '0) && !shift_by_shamt) |-> (op_a == id_ex.rs_data))
	else
	begin
		$error("rs forwarded although it is register 0");
		fail_count++;
	end

	rt_r0_not_forwarded: assert property (@(posedge clk) disable iff (reset)
		(id_ex.rt == '0) |-> (store_data == id_ex.rt_data))
	else
	begin
		$error("rt forwarded although it is register 0");
		fail_count++;
	end

	// --------------------
	// EX/MEM register
	// --------------------
	stall_holds_ex_mem: assert property (@(posedge clk) disable iff (reset)
		stall |=> $stable(ex_mem))
	else
	begin
		$error("EX/MEM changed while stalled");
		fail_count++;
	end

	// Bubble after flush, data fields are free
	flush_clears_ctrl: assert property (@(posedge clk) disable iff (reset)
		(flush && !stall) |=> (!ex_mem.wb_ctrl.reg_write && !ex_mem.mem_ctrl.mem_read
			&& !ex_mem.mem_ctrl.mem_write))
	else
	begin
		$error("control bits left set after flush");
		fail_count++;
	end

endmodule

// Stage top sees the operands and EX/MEM
bind execute_stage execute_stage_sva u_sva (
	.clk            (clk),
	.reset          (reset),
	.stall          (stall),
	.flush          (flush),
	.id_ex          (id_ex),
	.ex_mem         (ex_mem),
	.shift_by_shamt (shift_by_shamt),
	.op_a           (op_a),
	.store_data     (store_data)
);

`default_nettype wire

// File: verification/execute_stage_tb.sv
// Testbench for the execute stage
// Directed and random rows applied one per clock, each checked against
// a reference model of the ALU and forwarding rules

`timescale 1ns/1ns
`default_nettype none

`include "ex_macros.svh"

module execute_stage_tb
	import isa_pkg::*;
	import pipe_pkg::*;
();

	localparam int      CLK_PERIOD   = 100;
	localparam int      RESET_CYCLES = 16;
	localparam int      SLACK_CYCLES = 20;
	localparam int      N_RANDOM     = 24;
	localparam int      MSB          = `XLEN - 1;
	localparam wb_fwd_t NO_WB        = '0;

	typedef struct packed {
		id_ex_t  id_ex;
		wb_fwd_t wb;
		logic    flush;
		logic    stall;
		ex_mem_t exp; // EX/MEM one clock later
	} row_t;

	logic    clk;
	logic    reset;
	logic    stall;
	logic    flush;
	id_ex_t  id_ex;
	wb_fwd_t wb;
	ex_mem_t ex_mem;

	row_t    rows[$];
	ex_mem_t model_q; // Expected EX/MEM after the last queued row
	integer  seed;
	int      n_rows = 0;

	execute_stage UUT (
		.clk    (clk),
		.reset  (reset),
		.stall  (stall),
		.flush  (flush),
		.id_ex  (id_ex),
		.wb     (wb),
		.ex_mem (ex_mem)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// --------------------
	// Instruction builders
	// --------------------
	function automatic id_ex_t r_type(input funct_e f, input logic [4:0] shamt,
		input logic [`REG_AW-1:0] rs, rt, rd, input logic [MSB:0] a, b);
		id_ex_t ix;
		ix                   = '0;
		ix.rs                = rs;
		ix.rt                = rt;
		ix.rd                = rd;
		ix.rs_data           = a;
		ix.rt_data           = b;
		ix.imm               = {{(`XLEN-11){1'b0}}, shamt, f}; // shamt and funct fields
		ix.alu_op            = FUNCT_OP;
		ix.reg_dst_rd        = 1'b1;
		ix.wb_ctrl.reg_write = 1'b1;
		return ix;
	endfunction

	function automatic id_ex_t i_type(input alu_op_e op, input logic [`REG_AW-1:0] rs, rt,
		input logic [MSB:0] a, imm);
		id_ex_t ix;
		ix                   = '0;
		ix.rs                = rs;
		ix.rt                = rt;
		ix.rs_data           = a;
		ix.rt_data           = ~a; // Must not reach operand B
		ix.imm               = imm;
		ix.alu_op            = op;
		ix.alu_src_imm       = 1'b1;
		ix.wb_ctrl.reg_write = 1'b1;
		return ix;
	endfunction

	function automatic id_ex_t with_ctrl(input id_ex_t ix, input mem_ctrl_t m,
		input wb_ctrl_t w);
		ix.mem_ctrl = m;
		ix.wb_ctrl  = w;
		return ix;
	endfunction

	// --------------------
	// Reference model
	// --------------------
	function automatic alu_ctrl_e ref_op(input id_ex_t ix);
		if (ix.alu_op != FUNCT_OP)
		begin
			case (ix.alu_op)
				ADD_OP:  return A_ADD;
				SUB_OP:  return A_SUB;
				AND_OP:  return A_AND;
				OR_OP:   return A_OR;
				SLT_OP:  return A_SLT;
				default: return A_LUI; // lui and spare classes
			endcase
		end
		case (ix.imm[5:0])
			SLL, SLLV: return A_SLL;
			SRL, SRLV: return A_SRL;
			SRA, SRAV: return A_SRA;
			DIV:       return A_DIV;
			ADD, ADDU: return A_ADD;
			SUB:       return A_SUB;
			AND:       return A_AND;
			OR:        return A_OR;
			XOR:       return A_XOR;
			NOR:       return A_NOR;
			SLT:       return A_SLT;
			default:   return A_MUL; // mult and unknown codes
		endcase
	endfunction

	// EX/MEM first, then WB, r0 never
	function automatic logic [MSB:0] fwd_value(input logic [`REG_AW-1:0] r,
		input logic [MSB:0] file_val, input wb_fwd_t wbv);
		if (r != 0 && model_q.wb_ctrl.reg_write && model_q.write_reg == r)
			return model_q.result;
		if (r != 0 && wbv.reg_write && wbv.rd == r)
			return wbv.data;
		return file_val;
	endfunction

	function automatic ex_mem_t model_next(input id_ex_t ix, input wb_fwd_t wbv,
		input logic fl);
		ex_mem_t        n;
		logic [MSB:0]   a;
		logic [MSB:0]   b;
		logic [MSB:0]   rt_v;
		logic [`XLEN:0] wide; // Extra sign bit for overflow
		n    = '0;
		a    = fwd_value(ix.rs, ix.rs_data, wbv);
		rt_v = fwd_value(ix.rt, ix.rt_data, wbv);
		b    = ix.alu_src_imm ? ix.imm : rt_v;
		if (ix.alu_op == FUNCT_OP && ix.imm[5:0] inside {SLL, SRL, SRA})
			a = {{(`XLEN-5){1'b0}}, ix.imm[10:6]}; // Fixed shift amount
		case (ref_op(ix))
			A_ADD:
			begin
				wide     = {a[MSB], a} + {b[MSB], b};
				n.result = wide[MSB:0];
				n.over   = wide[`XLEN] ^ wide[MSB]; // Sign and extension disagree
			end
			A_SUB:
			begin
				wide     = {a[MSB], a} - {b[MSB], b};
				n.result = wide[MSB:0];
				n.over   = wide[`XLEN] ^ wide[MSB];
			end
			A_AND: n.result = a & b;
			A_OR:  n.result = a | b;
			A_XOR: n.result = a ^ b;
			A_NOR: n.result = ~(a | b);
			A_SLT: n.result = ($signed(a) < $signed(b)) ? 1 : 0;
			A_MUL: n.result = a * b;
			A_DIV: n.result = (b == 0) ? '1 : a / b;
			A_SLL: n.result = b << a[4:0];
			A_SRL: n.result = b >> a[4:0];
			A_SRA: n.result = $signed(b) >>> a[4:0];
			default: n.result = {b[15:0], 16'h0000}; // lui
		endcase
		n.store_data = rt_v;
		n.write_reg  = ix.reg_dst_rd ? ix.rd : ix.rt;
		n.zero       = (n.result == 0);
		n.mem_ctrl   = fl ? '0 : ix.mem_ctrl;
		n.wb_ctrl    = fl ? '0 : ix.wb_ctrl;
		return n;
	endfunction

	task automatic add_row(input id_ex_t ix, input wb_fwd_t wbv, input logic fl,
		input logic st);
		row_t r;
		if (!st)
			model_q = model_next(ix, wbv, fl); // Stalled rows keep the old state
		r.id_ex = ix;
		r.wb    = wbv;
		r.flush = fl;
		r.stall = st;
		r.exp   = model_q;
		rows.push_back(r);
	endtask

	// --------------------
	// Stimulus table
	// --------------------
	task automatic add_directed_rows();
		// Register form ALU ops
		add_row(r_type(ADD,  0, 1, 2, 3, 32'd5, 32'd7), NO_WB, 0, 0);
		add_row(r_type(SUB,  0, 4, 5, 6, 32'd9, 32'd9), NO_WB, 0, 0); // Zero flag
		add_row(r_type(AND,  0, 1, 2, 3, 32'hf0f0_1234, 32'h0ff0_ffff), NO_WB, 0, 0);
		add_row(r_type(OR,   0, 4, 5, 6, 32'h1200_0034, 32'h0056_7800), NO_WB, 0, 0);
		add_row(r_type(XOR,  0, 1, 2, 3, 32'haaaa_5555, 32'hffff_0000), NO_WB, 0, 0);
		add_row(r_type(NOR,  0, 4, 5, 6, 32'h0000_ff00, 32'h0f00_000f), NO_WB, 0, 0);
		add_row(r_type(SLT,  0, 1, 2, 3, -32'sd3, 32'd2), NO_WB, 0, 0); // Signed compare
		add_row(r_type(SLT,  0, 4, 5, 6, 32'd2, -32'sd3), NO_WB, 0, 0);
		add_row(r_type(MULT, 0, 1, 2, 3, 32'h0001_0003, 32'h0002_0005), NO_WB, 0, 0);
		add_row(r_type(DIV,  0, 4, 5, 6, 32'd100, 32'd7), NO_WB, 0, 0);
		add_row(r_type(DIV,  0, 1, 2, 3, 32'd100, 32'd0), NO_WB, 0, 0); // All ones
		add_row(r_type(funct_e'(6'd63), 0, 4, 5, 6, 32'd6, 32'd7), NO_WB, 0, 0);
		add_row(r_type(ADD,  0, 1, 2, 3, 32'h7fff_ffff, 32'd1), NO_WB, 0, 0); // Overflow
		add_row(r_type(SUB,  0, 4, 5, 6, 32'h8000_0000, 32'd1), NO_WB, 0, 0);
		add_row(r_type(ADDU, 0, 1, 2, 3, 32'hffff_ffff, 32'd1), NO_WB, 0, 0); // Carry only
		// Shifts
		add_row(r_type(SLL,  4, 1, 2, 3, 32'd9, 32'h0000_00f1), NO_WB, 0, 0);
		add_row(r_type(SRL, 31, 4, 5, 6, 32'd0, 32'h8000_0000), NO_WB, 0, 0);
		add_row(r_type(SRA,  8, 1, 2, 3, 32'd1, 32'h8765_4321), NO_WB, 0, 0);
		add_row(r_type(SLLV, 0, 4, 5, 6, 32'd12, 32'h0000_0abc), NO_WB, 0, 0);
		add_row(r_type(SRAV, 0, 1, 2, 3, 32'h0000_0024, 32'hf000_0000), NO_WB, 0, 0);
		// Immediate forms write rt
		add_row(i_type(ADD_OP, 1, 7, 32'd40, -32'sd4), NO_WB, 0, 0);
		add_row(i_type(SUB_OP, 2, 7, 32'd40, 32'd40), NO_WB, 0, 0);
		add_row(i_type(AND_OP, 1, 7, 32'h1234_5678, 32'h0000_ff0f), NO_WB, 0, 0);
		add_row(i_type(OR_OP,  2, 7, 32'h1234_0000, 32'h0000_5678), NO_WB, 0, 0);
		add_row(i_type(SLT_OP, 1, 7, -32'sd10, -32'sd9), NO_WB, 0, 0);
		add_row(i_type(LUI_OP, 0, 7, 32'd0, 32'h0000_beef), NO_WB, 0, 0);
		// Forwarding
		add_row(r_type(ADD, 0, 1, 2, 8, 32'd10, 32'd20), NO_WB, 0, 0);
		add_row(r_type(SUB, 0, 8, 2, 9, 32'd0, 32'd5), NO_WB, 0, 0); // r8 from EX/MEM
		add_row(r_type(OR, 0, 2, 8, 10, 32'd3, 32'd0),
			wb_fwd_t'{1'b1, 5'd8, 32'd30}, 0, 0); // r8 from WB
		add_row(r_type(ADD, 0, 10, 1, 11, 32'd0, 32'd1),
			wb_fwd_t'{1'b1, 5'd10, 32'hdead_beef}, 0, 0); // Both match
		add_row(r_type(ADD, 0, 1, 2, 0, 32'd4, 32'd4), NO_WB, 0, 0); // Writes r0
		add_row(r_type(ADD, 0, 0, 0, 12, 32'd0, 32'd0),
			wb_fwd_t'{1'b1, 5'd0, 32'h55}, 0, 0);
		add_row(r_type(ADD, 0, 1, 2, 13, 32'd100, 32'd23), NO_WB, 0, 0);
		add_row(with_ctrl(i_type(ADD_OP, 2, 13, 32'h1000, 32'h8), 3'b010, 2'b00),
			NO_WB, 0, 0); // Store of forwarded r13
		// Flush and stall
		add_row(with_ctrl(r_type(XOR, 0, 1, 2, 14, 32'hff, 32'h0f), 3'b101, 2'b11),
			NO_WB, 1, 0);
		add_row(with_ctrl(i_type(ADD_OP, 1, 15, 32'h2000, 32'h4), 3'b100, 2'b11),
			NO_WB, 0, 0); // Load
		add_row(r_type(ADD, 0, 1, 2, 3, 32'd1, 32'd1), NO_WB, 0, 1);
		add_row(r_type(SUB, 0, 1, 2, 3, 32'd1, 32'd1), NO_WB, 0, 1);
		add_row(r_type(AND, 0, 1, 2, 3, 32'd1, 32'd1), NO_WB, 1, 1); // Stall beats flush
		add_row(r_type(ADD, 0, 15, 15, 16, 32'd0, 32'd0), NO_WB, 0, 0); // Held EX/MEM
	endtask

	task automatic add_random_rows();
		funct_e picks[13] = '{ADD, ADDU, SUB, AND, OR, XOR, NOR, SLT, MULT, DIV, SLL,
			SRA, SRLV};
		funct_e             f;
		logic [4:0]         shamt;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [MSB:0]       a;
		logic [MSB:0]       b;
		wb_fwd_t            wbv;
		for (int i = 0; i < N_RANDOM; i++)
		begin
			f             = picks[$unsigned($random(seed)) % 13];
			shamt         = $random(seed);
			rs            = $unsigned($random(seed)) % 8; // Few registers, many hazards
			rt            = $unsigned($random(seed)) % 8;
			rd            = $unsigned($random(seed)) % 8;
			a             = $random(seed);
			b             = $random(seed);
			wbv.reg_write = $random(seed);
			wbv.rd        = $unsigned($random(seed)) % 8;
			wbv.data      = $random(seed);
			add_row(r_type(f, shamt, rs, rt, rd, a, b), wbv, 1'b0, 1'b0);
		end
	endtask

	// --------------------
	// Compare tasks
	// --------------------
	task automatic abort_run();
		$display("Test failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check_word(input string name, input logic [MSB:0] got, exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_reg(input string name, input logic [`REG_AW-1:0] got, exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: %s is r%0d, expected r%0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_mem_ctrl(input string name, input mem_ctrl_t got, exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_wb_ctrl(input string name, input wb_ctrl_t got, exp);
		if (got !== exp)
		begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_row(input int i);
		ex_mem_t e;
		e = rows[i].exp;
		check_word($sformatf("row %0d result", i), ex_mem.result, e.result);
		check_word($sformatf("row %0d store_data", i), ex_mem.store_data, e.store_data);
		check_reg($sformatf("row %0d write_reg", i), ex_mem.write_reg, e.write_reg);
		check_flag($sformatf("row %0d zero", i), ex_mem.zero, e.zero);
		check_flag($sformatf("row %0d over", i), ex_mem.over, e.over);
		check_mem_ctrl($sformatf("row %0d mem_ctrl", i), ex_mem.mem_ctrl, e.mem_ctrl);
		check_wb_ctrl($sformatf("row %0d wb_ctrl", i), ex_mem.wb_ctrl, e.wb_ctrl);
		if (UUT.u_sva.fail_count != 0)
		begin
			$display("A bound assertion fired before row %0d was checked", i);
			abort_run();
		end
	endtask

	// --------------------
	// Main sequence
	// --------------------
	initial
	begin
		seed    = 32'h56a7b5d6;
		clk     = 1'b0;
		reset   = 1'b1;
		stall   = 1'b0;
		flush   = 1'b0;
		id_ex   = '0;
		wb      = '0;
		model_q = '0; // EX/MEM right after reset
		add_directed_rows();
		add_random_rows();
		n_rows = rows.size();
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;
		check_mem_ctrl("mem_ctrl after reset", ex_mem.mem_ctrl, '0);
		check_wb_ctrl("wb_ctrl after reset", ex_mem.wb_ctrl, '0);
		for (int i = 0; i < n_rows; i++)
		begin
			id_ex = rows[i].id_ex; // Falling edge drive
			wb    = rows[i].wb;
			flush = rows[i].flush;
			stall = rows[i].stall;
			@(negedge clk);
			check_row(i);
		end
		if (UUT.u_sva.fail_count == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("Bound assertions failed %0d times", UUT.u_sva.fail_count);
			abort_run();
		end
	end

	// Watchdog sized from the table length
	initial
	begin
		wait (n_rows > 0);
		#((n_rows + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
		$display("Timeout: the stimulus table did not finish in time");
		abort_run();
	end

endmodule

`default_nettype wire
